// ==== src/sdramPkg.sv ====
package sdramPkg;

	// ====================
	// command pins, packed as {cs, ras, cas, we}
	typedef enum logic [3:0] {
		cmdInhibit   = 4'b1111, // cs high, device deselected
		cmdNop       = 4'b0111, // selected, no operation
		cmdActive    = 4'b0011, // open a row in one bank
		cmdRead      = 4'b0101, // column read, burst start
		cmdWrite     = 4'b0100, // column write, burst start
		cmdPrecharge = 4'b0010, // close row, a10 high means all banks
		cmdAutoRef   = 4'b0001, // cbr refresh
		cmdLoadMode  = 4'b0000  // mode register from addr
	} sdramCmd_t;

	// everything one engine drives onto the pins, data excluded
	typedef struct packed {
		sdramCmd_t   cmd;
		logic [1:0]  ba;   // bank select
		logic [12:0] addr; // row on activate, column on rd/wr
	} sdramBus_t;

	// ====================
	// user side types
	typedef logic [15:0] sysAddr_t;   // [14:13] bank, [12:0] row, bit 15 spare
	typedef logic [31:0] data_t;      // one dq word
	typedef logic [12:0] fifoLevel_t; // fill count of the external FIFOs

	// row span of one transfer
	typedef struct packed {
		sysAddr_t first; // first row moved
		sysAddr_t last;  // end row, not moved
	} addrRange_t;

	// ====================
	// device constants
	// mode word:
	//   [2:0] 111 full page burst
	//   [3]   0 sequential
	//   [6:4] 011 cas latency 3
	//   [9]   0 burst applies to writes too
	localparam logic [12:0] ModeRegValue = 13'h037;

	localparam int unsigned CasLatency       = 3;  // must match ModeRegValue[6:4]
	localparam int unsigned PostRowRefreshes = 3;  // refreshes after every row
	localparam int unsigned RefreshGap       = 11; // idle cycles after refresh or precharge

	// bus value while nothing is selected
	localparam sdramBus_t InhibitBus = '{cmd: cmdInhibit, ba: 2'b00, addr: 13'd0};

endpackage

// ==== src/sdramInit.sv ====
`timescale 1ns/1ps

module sdramInit import sdramPkg::*; #(
	parameter int unsigned InitWaitCycles = 14000 // power-up wait in cycles
) (
	input  logic      sys_clk,
	input  logic      nRST,
	output sdramBus_t initBus,
	output logic      initDone
);

	// one-hot sequence
	typedef enum logic [4:0] {
		powerWait    = 5'b00001,
		prechargeAll = 5'b00010,
		refreshAll   = 5'b00100,
		loadMode     = 5'b01000,
		initEnd      = 5'b10000
	} initState_t;

	localparam int unsigned WaitW     = $clog2(InitWaitCycles + 1);
	localparam int unsigned ShortGap  = 3; // idle after precharge-all and load-mode
	localparam int unsigned InitRefs  = 8;

	initState_t       state;
	logic [WaitW-1:0] waitCnt; // power-up wait
	logic [3:0]       gapCnt;  // idle cycles after a command
	logic [2:0]       refCnt;  // refreshes issued

	always_ff @(posedge sys_clk or negedge nRST)
	begin
		if (!nRST)
		begin
			state    <= powerWait;
			waitCnt  <= '0;
			gapCnt   <= '0;
			refCnt   <= '0;
			initBus  <= InhibitBus;
			initDone <= 1'b0;
		end
		else
		begin
			initBus.cmd <= cmdInhibit; // every idle cycle
			case (state)
				powerWait:
				begin
					if (waitCnt == WaitW'(InitWaitCycles - 1))
					begin
						waitCnt <= '0;
						state   <= prechargeAll;
					end
					else
						waitCnt <= waitCnt + 1'b1;
				end
				prechargeAll:
				begin
					if (gapCnt == 4'd0)
					begin
						initBus <= '{cmd: cmdPrecharge, ba: 2'b00, addr: 13'h0400}; // a10 set
						gapCnt  <= gapCnt + 1'b1;
					end
					else if (gapCnt == 4'(ShortGap))
					begin
						gapCnt <= '0;
						state  <= refreshAll;
					end
					else
						gapCnt <= gapCnt + 1'b1;
				end
				refreshAll:
				begin
					if (gapCnt == 4'd0)
					begin
						initBus.cmd <= cmdAutoRef;
						gapCnt      <= gapCnt + 1'b1;
					end
					else if (gapCnt == 4'(RefreshGap))
					begin
						gapCnt <= '0;
						refCnt <= refCnt + 1'b1; // wraps to 0 after the eighth
						if (refCnt == 3'(InitRefs - 1))
							state <= loadMode;
					end
					else
						gapCnt <= gapCnt + 1'b1;
				end
				loadMode:
				begin
					if (gapCnt == 4'd0)
					begin
						initBus <= '{cmd: cmdLoadMode, ba: 2'b00, addr: ModeRegValue};
						gapCnt  <= gapCnt + 1'b1;
					end
					else if (gapCnt == 4'(ShortGap))
					begin
						gapCnt <= '0;
						state  <= initEnd;
					end
					else
						gapCnt <= gapCnt + 1'b1;
				end
				default:
					initDone <= 1'b1; // initEnd, held until reset
			endcase
		end
	end

endmodule

// ==== src/refreshTimer.sv ====
`timescale 1ns/1ps

module refreshTimer #(
	parameter int unsigned RefreshInterval = 781 // cycles between refresh requests
) (
	input  logic sys_clk,
	input  logic nRST,
	input  logic enable, // device ready
	input  logic refAck, // one-cycle pulse from the engine
	output logic refReq
);

	localparam int unsigned CntW = $clog2(RefreshInterval + 1);

	logic [CntW-1:0] count;

	// ====================
	// interval count, request held until acknowledged
	always_ff @(posedge sys_clk or negedge nRST)
	begin
		if (!nRST)
		begin
			count  <= '0;
			refReq <= 1'b0;
		end
		else if (!enable || refAck)
		begin
			count  <= '0; // restart interval
			refReq <= 1'b0;
		end
		else if (count == CntW'(RefreshInterval - 1))
			refReq <= 1'b1; // count parks here while pending
		else
			count <= count + 1'b1;
	end

endmodule

// ==== src/sdramWriter.sv ====
`timescale 1ns/1ps

module sdramWriter import sdramPkg::*; #(
	parameter int unsigned PageWords       = 1024,
	parameter int unsigned RefreshInterval = 781,
	parameter int unsigned EmptyLevel      = 1200 // upstream words needed per row
) (
	input  logic       sys_clk,
	input  logic       nRST,
	input  logic       initDone,
	input  logic       start,
	input  addrRange_t range,
	input  data_t      preFifoData, // show-ahead head word
	input  fifoLevel_t preFifoLevel,
	output logic       preFifoRdEn,
	output sdramBus_t  wrBus,
	output data_t      wrData,
	output logic       busy
);

	typedef enum logic [3:0] {
		idle     = 4'b0001,
		waitData = 4'b0010,
		burst    = 4'b0100,
		refresh  = 4'b1000
	} wrState_t;

	// ====================
	// burst counter marks
	localparam int unsigned RdEnAt   = 2;                      // pop starts
	localparam int unsigned WriteAt  = 3;                      // write cmd, word 0 latched
	localparam int unsigned LastWord = PageWords + 2;          // last word latched
	localparam int unsigned PrechAt  = PageWords + 3;
	localparam int unsigned RowEnd   = PrechAt + RefreshGap;   // row index steps
	localparam int unsigned CntW     = $clog2(RowEnd + 1);

	wrState_t        state;
	logic [CntW-1:0] cnt;
	logic [3:0]      gapCnt;  // refresh spacing
	logic [1:0]      refLeft; // refreshes still owed
	sysAddr_t        rowIdx;
	logic            refReq;
	logic            refAck;
	logic            latchWord;

	refreshTimer #(.RefreshInterval(RefreshInterval)) refTimer (
		.sys_clk(sys_clk),
		.nRST   (nRST),
		.enable (initDone),
		.refAck (refAck),
		.refReq (refReq)
	);

	// word popped this cycle goes out with the next bus cycle
	assign latchWord = (state == burst) && (cnt >= WriteAt) && (cnt <= LastWord);

	always_ff @(posedge sys_clk)
	begin
		if (latchWord)
			wrData <= preFifoData;
	end

	always_ff @(posedge sys_clk or negedge nRST)
	begin
		if (!nRST)
		begin
			state       <= idle;
			cnt         <= '0;
			gapCnt      <= '0;
			refLeft     <= '0;
			rowIdx      <= '0;
			refAck      <= 1'b0;
			preFifoRdEn <= 1'b0;
			wrBus       <= InhibitBus;
			busy        <= 1'b0;
		end
		else
		begin
			wrBus.cmd <= cmdNop; // default gap cycle
			refAck    <= 1'b0;
			case (state)
				idle:
				begin
					if (refReq)
					begin
						refAck  <= 1'b1; // timer restarts
						refLeft <= 2'd1;
						state   <= refresh;
					end
					else if (!start || !initDone)
					begin
						rowIdx <= range.first; // arm next transfer
						busy   <= 1'b0;
					end
					else if (rowIdx < range.last)
					begin
						busy  <= 1'b1;
						state <= waitData;
					end
					else
						busy <= 1'b0; // range done, start still high
				end
				waitData:
				begin
					if (refReq)
					begin
						refAck  <= 1'b1;
						refLeft <= 2'd1;
						state   <= refresh;
					end
					else if (preFifoLevel >= EmptyLevel)
						state <= burst; // a full page is buffered
				end
				burst:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == 0)
						wrBus <= '{cmd: cmdActive, ba: rowIdx[14:13], addr: rowIdx[12:0]};
					else if (cnt == WriteAt)
						wrBus <= '{cmd: cmdWrite, ba: rowIdx[14:13], addr: 13'd0}; // col 0
					else if (cnt == PrechAt)
						wrBus <= '{cmd: cmdPrecharge, ba: rowIdx[14:13], addr: 13'd0}; // ends burst
					if (cnt == RdEnAt)
						preFifoRdEn <= 1'b1;
					else if (cnt == LastWord)
						preFifoRdEn <= 1'b0; // exactly PageWords pops
					if (cnt == RowEnd)
					begin
						cnt     <= '0;
						rowIdx  <= rowIdx + 1'b1;
						refLeft <= 2'(PostRowRefreshes);
						state   <= refresh;
					end
				end
				default: // refresh
				begin
					if (gapCnt == 4'd0)
					begin
						wrBus.cmd <= cmdAutoRef;
						gapCnt    <= gapCnt + 1'b1;
					end
					else if (gapCnt == 4'(RefreshGap))
					begin
						gapCnt  <= '0;
						refLeft <= refLeft - 1'b1;
						if (refLeft == 2'd1)
							state <= idle; // idle decides the next row
					end
					else
						gapCnt <= gapCnt + 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== src/sdramReader.sv ====
`timescale 1ns/1ps

module sdramReader import sdramPkg::*; #(
	parameter int unsigned PageWords       = 1024,
	parameter int unsigned RefreshInterval = 781,
	parameter int unsigned FullLevel       = 3000 // downstream room limit per row
) (
	input  logic       sys_clk,
	input  logic       nRST,
	input  logic       initDone,
	input  logic       start,
	input  addrRange_t range,
	input  data_t      rdData, // dq pins
	input  fifoLevel_t postFifoLevel,
	output data_t      postFifoData,
	output logic       postFifoWrEn,
	output sdramBus_t  rdBus,
	output logic       busy
);

	typedef enum logic [3:0] {
		idle     = 4'b0001,
		waitData = 4'b0010,
		burst    = 4'b0100,
		refresh  = 4'b1000
	} rdState_t;

	// ====================
	// burst counter marks
	localparam int unsigned ReadAt    = 3;                     // read cmd, col 0
	localparam int unsigned DelayAt   = 4;                     // cnt parks for cas latency
	localparam int unsigned FirstWord = 5;
	localparam int unsigned PrechAt   = PageWords + 1;         // PageWords after read cmd
	localparam int unsigned LastWord  = PageWords + 4;
	localparam int unsigned RowEnd    = PrechAt + RefreshGap;
	localparam int unsigned CntW      = $clog2(RowEnd + 1);

	rdState_t        state;
	logic [CntW-1:0] cnt;
	logic [1:0]      dly;      // cas latency wait
	logic [3:0]      gapCnt;
	logic [1:0]      refLeft;
	logic            fromIdle; // refresh return target
	sysAddr_t        rowIdx;
	logic            refReq;
	logic            refAck;
	logic            inWindow;

	refreshTimer #(.RefreshInterval(RefreshInterval)) refTimer (
		.sys_clk(sys_clk),
		.nRST   (nRST),
		.enable (initDone),
		.refAck (refAck),
		.refReq (refReq)
	);

	// dq carries valid read data in these cycles
	assign inWindow = (state == burst) && (cnt >= FirstWord) && (cnt <= LastWord);

	always_ff @(posedge sys_clk)
	begin
		if (inWindow)
			postFifoData <= rdData;
	end

	always_ff @(posedge sys_clk or negedge nRST)
	begin
		if (!nRST)
		begin
			state        <= idle;
			cnt          <= '0;
			dly          <= '0;
			gapCnt       <= '0;
			refLeft      <= '0;
			fromIdle     <= 1'b0;
			rowIdx       <= '0;
			refAck       <= 1'b0;
			postFifoWrEn <= 1'b0;
			rdBus        <= InhibitBus;
			busy         <= 1'b0;
		end
		else
		begin
			rdBus.cmd    <= cmdNop;
			refAck       <= 1'b0;
			postFifoWrEn <= inWindow; // aligned with postFifoData
			case (state)
				idle:
				begin
					if (refReq)
					begin
						refAck   <= 1'b1;
						refLeft  <= 2'd1;
						fromIdle <= 1'b1;
						state    <= refresh;
					end
					else if (!start || !initDone)
					begin
						rowIdx <= range.first;
						busy   <= 1'b0;
					end
					else if (rowIdx != range.last)
					begin
						busy  <= 1'b1;
						state <= waitData;
					end
					else
						busy <= 1'b0;
				end
				waitData:
				begin
					if (refReq)
					begin
						refAck   <= 1'b1;
						refLeft  <= 2'd1;
						fromIdle <= 1'b0;
						state    <= refresh;
					end
					else if (rowIdx == range.last)
					begin
						busy  <= 1'b0; // range finished
						state <= idle;
					end
					else if (postFifoLevel <= FullLevel)
						state <= burst;
				end
				burst:
				begin
					if (cnt == DelayAt && dly != 2'(CasLatency - 1))
						dly <= dly + 1'b1;
					else
					begin
						dly <= '0;
						cnt <= cnt + 1'b1;
					end
					if (cnt == 0)
						rdBus <= '{cmd: cmdActive, ba: rowIdx[14:13], addr: rowIdx[12:0]};
					else if (cnt == ReadAt)
						rdBus <= '{cmd: cmdRead, ba: rowIdx[14:13], addr: 13'd0};
					else if (cnt == PrechAt)
						rdBus <= '{cmd: cmdPrecharge, ba: rowIdx[14:13], addr: 13'd0}; // stops burst
					if (cnt == RowEnd)
					begin
						cnt      <= '0;
						rowIdx   <= rowIdx + 1'b1;
						refLeft  <= 2'(PostRowRefreshes);
						fromIdle <= 1'b0;
						state    <= refresh;
					end
				end
				default: // refresh
				begin
					if (gapCnt == 4'd0)
					begin
						rdBus.cmd <= cmdAutoRef;
						gapCnt    <= gapCnt + 1'b1;
					end
					else if (gapCnt == 4'(RefreshGap))
					begin
						gapCnt  <= '0;
						refLeft <= refLeft - 1'b1;
						if (refLeft == 2'd1)
							state <= fromIdle ? idle : waitData;
					end
					else
						gapCnt <= gapCnt + 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== src/sdramCtrl.sv ====
`timescale 1ns/1ps

module sdramCtrl import sdramPkg::*; #(
	parameter int unsigned PageWords       = 1024,  // words per row burst
	parameter int unsigned InitWaitCycles  = 14000, // 140 us at 100 MHz
	parameter int unsigned RefreshInterval = 781,   // 7.81 us at 100 MHz
	parameter int unsigned EmptyLevel      = 1200,
	parameter int unsigned FullLevel       = 3000
) (
	input  logic       sys_clk,
	input  logic       nRST,
	// ====================
	input  data_t      preFifoData,
	input  fifoLevel_t preFifoLevel,
	output logic       preFifoRdEn,
	output data_t      postFifoData,
	output logic       postFifoWrEn,
	input  fifoLevel_t postFifoLevel,
	// ====================
	input  addrRange_t writeRange,
	input  addrRange_t readRange,
	input  logic       writeStart,
	input  logic       readStart,
	input  logic       pingPong,   // 1 writer owns the bus, 0 reader
	output logic       writeBusy,
	output logic       readBusy,
	output logic       initDone,
	// ====================
	output logic       sdCke,
	output sdramBus_t  sdBus,
	output logic [3:0] sdDqm,      // one per byte lane
	inout  wire data_t sdDq
);

	sdramBus_t initBus;
	sdramBus_t wrBus;
	sdramBus_t rdBus;
	data_t     wrData;

	sdramInit #(.InitWaitCycles(InitWaitCycles)) init (
		.sys_clk (sys_clk),
		.nRST    (nRST),
		.initBus (initBus),
		.initDone(initDone)
	);

	sdramWriter #(
		.PageWords      (PageWords),
		.RefreshInterval(RefreshInterval),
		.EmptyLevel     (EmptyLevel)
	) writer (
		.sys_clk     (sys_clk),
		.nRST        (nRST),
		.initDone    (initDone),
		.start       (writeStart & pingPong), // only while owner
		.range       (writeRange),
		.preFifoData (preFifoData),
		.preFifoLevel(preFifoLevel),
		.preFifoRdEn (preFifoRdEn),
		.wrBus       (wrBus),
		.wrData      (wrData),
		.busy        (writeBusy)
	);

	sdramReader #(
		.PageWords      (PageWords),
		.RefreshInterval(RefreshInterval),
		.FullLevel      (FullLevel)
	) reader (
		.sys_clk      (sys_clk),
		.nRST         (nRST),
		.initDone     (initDone),
		.start        (readStart & ~pingPong),
		.range        (readRange),
		.rdData       (sdDq),
		.postFifoLevel(postFifoLevel),
		.postFifoData (postFifoData),
		.postFifoWrEn (postFifoWrEn),
		.rdBus        (rdBus),
		.busy         (readBusy)
	);

	// pin owner: init sequencer first, then by pingPong
	always_comb
	begin
		if (!initDone)
			sdBus = initBus;
		else if (pingPong)
			sdBus = wrBus;
		else
			sdBus = rdBus;
	end

	assign sdDq  = pingPong ? wrData : 'z; // released for reads
	assign sdCke = 1'b1;
	assign sdDqm = '0; // all lanes always enabled

endmodule

// ==== bench/sdramModel.sv ====
`timescale 1ns/1ps

module sdramModel import sdramPkg::*; #(
	parameter int unsigned PageWords = 16 // columns kept per row
) (
	input  logic      sys_clk,
	input  sdramBus_t sdBus,
	inout  wire data_t sdDq
);

	localparam int unsigned Depth = 4 * 16 * PageWords; // 4 banks, 16 rows each

	data_t       mem [Depth];
	logic [3:0]  openRow [4];      // low row bits per bank
	logic [1:0]  burstBa  = 2'b00;
	int unsigned burstCol = 0;
	logic        writing  = 1'b0;
	logic        reading  = 1'b0;
	logic [2:0]  pipeValid = '0;   // cas latency pipe
	data_t       pipeData [3];

	function automatic int unsigned memIdx(input logic [1:0] ba, input logic [3:0] row,
		input int unsigned col);
		return (int'(ba) * 16 + int'(row)) * PageWords + col;
	endfunction

	initial
	begin
		for (int i = 0; i < Depth; i++)
			mem[i] = data_t'(i) ^ 32'h5a5a_0000; // pattern over the whole address
	end

	always @(posedge sys_clk)
	begin
		logic  issue;
		data_t issueWord;
		issue     = 1'b0;
		issueWord = '0;
		case (sdBus.cmd)
			cmdActive:
			begin
				openRow[sdBus.ba] <= sdBus.addr[3:0];
				writing <= 1'b0;
				reading <= 1'b0;
			end
			cmdWrite:
			begin
				mem[memIdx(sdBus.ba, openRow[sdBus.ba], 0)] <= sdDq; // word 0 with the command
				burstBa  <= sdBus.ba;
				burstCol <= 1;
				writing  <= 1'b1;
				reading  <= 1'b0;
			end
			cmdRead:
			begin
				issue     = 1'b1;
				issueWord = mem[memIdx(sdBus.ba, openRow[sdBus.ba], 0)];
				burstBa  <= sdBus.ba;
				burstCol <= 1;
				reading  <= 1'b1;
				writing  <= 1'b0;
			end
			cmdNop, cmdInhibit:
			begin
				if (writing && burstCol < PageWords)
				begin
					mem[memIdx(burstBa, openRow[burstBa], burstCol)] <= sdDq;
					burstCol <= burstCol + 1;
				end
				if (reading && burstCol < PageWords)
				begin
					issue     = 1'b1;
					issueWord = mem[memIdx(burstBa, openRow[burstBa], burstCol)];
					burstCol <= burstCol + 1;
				end
			end
			default:
			begin
				writing <= 1'b0; // precharge, refresh, mode load end a burst
				reading <= 1'b0;
			end
		endcase
		pipeValid   <= {pipeValid[1:0], issue};
		pipeData[0] <= issueWord;
		pipeData[1] <= pipeData[0];
		pipeData[2] <= pipeData[1];
	end

	assign sdDq = pipeValid[2] ? pipeData[2] : 'z; // valid at edge three after issue

endmodule

// ==== bench/sdramCtrl_sva.sv ====
`timescale 1ns/1ps

module sdramCtrl_sva import sdramPkg::*; (
	input logic      sys_clk,
	input logic      nRST,
	input logic      initDone,
	input sdramBus_t sdBus,
	input logic      preFifoRdEn,
	input logic      postFifoWrEn
);

	logic [3:0]  rowOpen;       // one per bank
	int unsigned failCount = 0; // failed assertions so far

	always_ff @(posedge sys_clk or negedge nRST)
	begin
		if (!nRST)
			rowOpen <= '0;
		else if (sdBus.cmd == cmdActive)
			rowOpen[sdBus.ba] <= 1'b1;
		else if (sdBus.cmd == cmdPrecharge)
		begin
			if (sdBus.addr[10])
				rowOpen <= '0; // all banks
			else
				rowOpen[sdBus.ba] <= 1'b0;
		end
	end

	// ====================
	initOnlyBeforeDone: assert property (@(posedge sys_clk) disable iff (!nRST)
		!initDone |-> sdBus.cmd inside {cmdInhibit, cmdPrecharge, cmdAutoRef, cmdLoadMode})
		else
		begin
			$error("engine command on the pins before init finished");
			failCount++;
		end

	fifoExclusive: assert property (@(posedge sys_clk) disable iff (!nRST)
		!(preFifoRdEn && postFifoWrEn))
		else
		begin
			$error("upstream pop and downstream push in the same cycle");
			failCount++;
		end

	accessInOpenRow: assert property (@(posedge sys_clk) disable iff (!nRST)
		(sdBus.cmd == cmdWrite || sdBus.cmd == cmdRead) |-> rowOpen[sdBus.ba])
		else
		begin
			$error("column access to a bank with no open row");
			failCount++;
		end

endmodule

bind sdramCtrl sdramCtrl_sva sva (.*);

// ==== bench/sdramCtrl_tb.sv ====
`timescale 1ns/1ps

module sdramCtrl_tb import sdramPkg::*;;

	localparam int unsigned PageWords       = 16;
	localparam int unsigned InitWaitCycles  = 20;
	localparam int unsigned RefreshInterval = 300;
	localparam int unsigned EmptyLevel      = 1200;
	localparam int unsigned FullLevel       = 3000;
	localparam int unsigned NumEntries      = 5;
	localparam int unsigned DirRead         = 0;
	localparam int unsigned DirWrite        = 1;
	localparam int unsigned DirBlocked      = 2; // write start while reader owns the bus
	localparam int unsigned ArmCycles       = RefreshGap + 4; // range settles before start

	typedef struct {
		int unsigned dir;
		sysAddr_t    first;
		sysAddr_t    last;   // exclusive
		int unsigned stall;  // cycles of bad fill level
		int unsigned rows;   // expected row count
	} stimEntry_t;

	logic       sys_clk;
	logic       nRST;
	data_t      preFifoData;
	fifoLevel_t preFifoLevel;
	logic       preFifoRdEn;
	data_t      postFifoData;
	logic       postFifoWrEn;
	fifoLevel_t postFifoLevel;
	addrRange_t writeRange;
	addrRange_t readRange;
	logic       writeStart;
	logic       readStart;
	logic       pingPong;
	logic       writeBusy;
	logic       readBusy;
	logic       initDone;
	logic       sdCke;
	sdramBus_t  sdBus;
	logic [3:0] sdDqm;
	wire data_t sdDq;

	stimEntry_t  stim [NumEntries];
	data_t       expMem [16 * PageWords]; // row low bits, column
	logic [31:0] lfsr;
	int unsigned valueErrors = 0;
	int unsigned otherErrors = 0;
	int unsigned activeCnt   = 0;
	int unsigned popCnt      = 0;
	int unsigned pushCnt     = 0;
	int unsigned writeCmdCnt = 0;
	int unsigned refCount    = 0;
	longint      cycleNo     = 0;
	longint      lastRef     = -1;
	logic        refCheckOn  = 1'b0;
	logic        initChecked = 1'b0;
	sysAddr_t    curFirst    = '0;
	sdramCmd_t   initCmds [$];
	logic [12:0] initAddrs [$];

	sdramCtrl #(
		.PageWords      (PageWords),
		.InitWaitCycles (InitWaitCycles),
		.RefreshInterval(RefreshInterval),
		.EmptyLevel     (EmptyLevel),
		.FullLevel      (FullLevel)
	) UUT (.*);

	sdramModel #(.PageWords(PageWords)) sdram (
		.sys_clk(sys_clk),
		.sdBus  (sdBus),
		.sdDq   (sdDq)
	);

	always #50 sys_clk = ~sys_clk;

	// ====================
	// compare tasks
	task automatic checkData(input string name, input data_t got, input data_t exp);
		if (got !== exp)
		begin
			valueErrors++;
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkCmd(input string name, input sdramCmd_t got, input sdramCmd_t exp);
		if (got !== exp)
		begin
			valueErrors++;
			$display("Error at %0t ns: %s = %s, expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			valueErrors++;
			$display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkAddr(input string name, input sysAddr_t got, input sysAddr_t exp);
		if (got !== exp)
		begin
			valueErrors++;
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkCount(input string name, input int unsigned got, input int unsigned exp);
		if (got != exp)
		begin
			valueErrors++;
			$display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// ====================
	// galois lfsr, one step per bit
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
	endfunction

	function automatic data_t nextWord();
		data_t w;
		for (int i = 0; i < 32; i++)
		begin
			lfsr = lfsrStep(lfsr);
			w[i] = lfsr[0];
		end
		return w;
	endfunction

	function automatic int unsigned expIdx(input sysAddr_t row, input int unsigned col);
		return int'(row[3:0]) * PageWords + col;
	endfunction

	function automatic int unsigned modelIdx(input sysAddr_t row, input int unsigned col);
		return (int'(row[14:13]) * 16 + int'(row[3:0])) * PageWords + col;
	endfunction

	// ====================
	// show-ahead upstream FIFO, head advances on a pop
	always @(posedge sys_clk)
	begin
		cycleNo <= cycleNo + 1;
		if (preFifoRdEn)
			preFifoData <= nextWord();
	end

	// bus and FIFO monitor, between edges where outputs are stable
	always @(negedge sys_clk)
	begin
		if (nRST)
		begin
			checkFlag("sdCke", sdCke, 1'b1);
			for (int i = 0; i < 4; i++)
				checkFlag($sformatf("sdDqm[%0d]", i), sdDqm[i], 1'b0);
		end
		if (nRST && !initDone)
		begin
			checkFlag("preFifoRdEn", preFifoRdEn, 1'b0);
			checkFlag("postFifoWrEn", postFifoWrEn, 1'b0);
			checkFlag("writeBusy", writeBusy, 1'b0);
			checkFlag("readBusy", readBusy, 1'b0);
			if (sdBus.cmd != cmdInhibit)
			begin
				initCmds.push_back(sdBus.cmd);
				initAddrs.push_back(sdBus.addr);
			end
		end
		else if (initDone && !initChecked)
		begin
			initChecked = 1'b1;
			checkCount("init command count", initCmds.size(), 10);
			if (initCmds.size() == 10)
			begin
				checkCmd("init cmd 0", initCmds[0], cmdPrecharge);
				checkFlag("precharge a10", initAddrs[0][10], 1'b1);
				for (int i = 1; i < 9; i++)
					checkCmd("init refresh", initCmds[i], cmdAutoRef);
				checkCmd("init cmd 9", initCmds[9], cmdLoadMode);
				// full page, sequential, cas latency 3
				checkAddr("mode word", sysAddr_t'(initAddrs[9]), 16'h0037);
			end
		end
		if (initDone)
		begin
			if (sdBus.cmd == cmdActive)
			begin
				checkAddr("activate row", {1'b0, sdBus.ba, sdBus.addr},
					sysAddr_t'(curFirst + activeCnt));
				activeCnt++;
			end
			if (sdBus.cmd == cmdWrite)
				writeCmdCnt++;
			if (sdBus.cmd == cmdAutoRef && refCheckOn)
			begin
				if (lastRef >= 0 && cycleNo - lastRef > RefreshInterval + RefreshGap + 4)
				begin
					otherErrors++;
					$display("refresh gap of %0d cycles is too long at %0t ns",
						cycleNo - lastRef, $time);
				end
				lastRef = cycleNo;
				refCount++;
			end
			if (preFifoRdEn)
			begin
				expMem[expIdx(sysAddr_t'(curFirst + popCnt / PageWords), popCnt % PageWords)] =
					preFifoData;
				popCnt++;
			end
			if (postFifoWrEn)
			begin
				checkData("postFifoData", postFifoData,
					expMem[expIdx(sysAddr_t'(curFirst + pushCnt / PageWords),
					pushCnt % PageWords)]);
				pushCnt++;
			end
		end
	end

	// ====================
	// waits on the active engine's busy flag
	task automatic waitBusy(input int unsigned dir, input logic level, input int unsigned limit);
		int unsigned n;
		n = 0;
		while (((dir == DirWrite) ? writeBusy : readBusy) !== level && n < limit)
		begin
			@(posedge sys_clk);
			n++;
		end
		if (n >= limit)
		begin
			otherErrors++;
			$display("busy flag did not reach %b within %0d cycles at %0t ns", level, limit, $time);
		end
	endtask

	task automatic runEntry(input stimEntry_t e);
		@(posedge sys_clk);
		curFirst    = e.first;
		activeCnt   = 0;
		popCnt      = 0;
		pushCnt     = 0;
		writeCmdCnt = 0;
		pingPong      <= (e.dir == DirWrite);
		writeRange    <= '{first: e.first, last: e.last};
		readRange     <= '{first: e.first, last: e.last};
		preFifoLevel  <= (e.dir == DirWrite && e.stall > 0) ? 13'd0 : 13'd2000;
		postFifoLevel <= (e.dir == DirRead && e.stall > 0) ? 13'd4000 : 13'd0;
		// idle engines take the first row while start is low, even after a refresh
		repeat (ArmCycles) @(posedge sys_clk);
		writeStart    <= (e.dir != DirRead);
		readStart     <= (e.dir == DirRead);
		if (e.dir == DirBlocked)
		begin
			repeat (3 * (PageWords + 80)) @(posedge sys_clk);
			checkFlag("writeBusy", writeBusy, 1'b0);
		end
		else
		begin
			@(posedge sys_clk);
			waitBusy(e.dir, 1'b1, 40);
			if (e.stall > 0)
			begin
				repeat (e.stall) @(posedge sys_clk);
				checkCount("activates during stall", activeCnt, 0);
				checkCount("pushes during stall", pushCnt, 0);
				checkFlag("busy during stall", (e.dir == DirWrite) ? writeBusy : readBusy, 1'b1);
				preFifoLevel  <= 13'd2000;
				postFifoLevel <= 13'd0;
			end
			waitBusy(e.dir, 1'b0, e.rows * (PageWords + 80) + 500);
		end
		writeStart <= 1'b0;
		readStart  <= 1'b0;
		@(posedge sys_clk);
		checkCount("activates", activeCnt, e.rows);
		checkCount("write commands", writeCmdCnt, (e.dir == DirWrite) ? e.rows : 0);
		checkCount("upstream pops", popCnt, (e.dir == DirWrite) ? e.rows * PageWords : 0);
		checkCount("downstream pushes", pushCnt, (e.dir == DirRead) ? e.rows * PageWords : 0);
		if (e.dir == DirWrite)
		begin
			for (int r = 0; r < e.rows; r++)
				for (int c = 0; c < PageWords; c++)
					checkData("model memory",
						sdram.mem[modelIdx(sysAddr_t'(e.first + r), c)],
						expMem[expIdx(sysAddr_t'(e.first + r), c)]);
		end
	endtask

	// ====================
	// watchdog sized from the table
	initial
	begin
		longint limit;
		#1;
		limit = InitWaitCycles + 400 + 3 * RefreshInterval + 2000;
		for (int i = 0; i < NumEntries; i++)
			limit += (stim[i].rows + 3) * (PageWords + 80) + stim[i].stall + ArmCycles;
		repeat (limit) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, run stopped", limit);
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		int unsigned n;
		stim[0] = '{DirWrite,   16'd2, 16'd5, 0,   3};
		stim[1] = '{DirRead,    16'd2, 16'd5, 0,   3};
		stim[2] = '{DirWrite,   16'd6, 16'd8, 150, 2};
		stim[3] = '{DirRead,    16'd6, 16'd8, 150, 2};
		stim[4] = '{DirBlocked, 16'd9, 16'd11, 0,  0};
		lfsr          = 32'hac7706d0;
		sys_clk       = 1'b0;
		nRST          = 1'b0;
		preFifoData   = nextWord();
		preFifoLevel  = '0;
		postFifoLevel = '0;
		writeRange    = '0;
		readRange     = '0;
		writeStart    = 1'b0;
		readStart     = 1'b0;
		pingPong      = 1'b1;
		repeat (3) @(posedge sys_clk);
		nRST <= 1'b1;
		n = 0;
		while (!initDone && n < InitWaitCycles + 400)
		begin
			@(posedge sys_clk);
			n++;
		end
		if (!initDone)
		begin
			otherErrors++;
			$display("initDone never rose after reset");
		end
		// idle refresh spacing, writer on the pins
		refCheckOn = 1'b1;
		repeat (3 * RefreshInterval + 50) @(posedge sys_clk);
		refCheckOn = 1'b0;
		if (refCount < 2)
		begin
			otherErrors++;
			$display("only %0d refreshes seen while idle", refCount);
		end
		for (int i = 0; i < NumEntries; i++)
			runEntry(stim[i]);
		$display("value errors: %0d, other errors: %0d, assertion failures: %0d",
			valueErrors, otherErrors, UUT.sva.failCount);
		if (valueErrors == 0 && otherErrors == 0 && UUT.sva.failCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== src.f ====
src/sdramPkg.sv
src/sdramInit.sv
src/refreshTimer.sv
src/sdramWriter.sv
src/sdramReader.sv
src/sdramCtrl.sv
bench/sdramModel.sv
bench/sdramCtrl_sva.sv
bench/sdramCtrl_tb.sv

// ==== Bender.yml ====
package:
  name: sdram_ctrl

sources:
  - src/sdramPkg.sv
  - src/sdramInit.sv
  - src/refreshTimer.sv
  - src/sdramWriter.sv
  - src/sdramReader.sv
  - src/sdramCtrl.sv
  - target: simulation
    files:
      - bench/sdramModel.sv
      - bench/sdramCtrl_sva.sv
      - bench/sdramCtrl_tb.sv
